/* ddr3_arbit.f */
ddr3_arbit_pkg.sv
pack_fifo.sv
unpack_fifo.sv
burst_addr_gen.sv
burst_arbiter.sv
burst_writer.sv
burst_reader.sv
ddr3_arbit.sv
ddr3_arbit_properties.sv
tb_ddr3_arbit.sv

/* Makefile */
SIM = obj_dir/sim_ddr3_arbit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_ddr3_arbit \
		-f ddr3_arbit.f -o sim_ddr3_arbit --Mdir obj_dir

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

/* tb_ddr3_arbit.sv */
`timescale 1ns/100ps

module tb_ddr3_arbit;

  localparam int TIMEOUT = 600;  // cycles allowed per wait

  logic                                     clk;
  logic                                     rst_n;
  logic                                     wr_req;
  ddr3_arbit_pkg::addr_window_t             wr_window;
  logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] wr_din;
  logic                                     wr_din_vld;
  logic                                     rd_req;
  ddr3_arbit_pkg::addr_window_t             rd_window;
  logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] rd_dout;
  logic                                     rd_dout_vld;
  logic                                     init_calib_complete;
  logic                                     app_en;
  logic [2:0]                               app_cmd;
  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0]    app_addr;
  logic                                     app_rdy;
  logic                                     app_wdf_rdy;
  logic                                     app_wdf_wren;
  logic                                     app_wdf_end;
  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    app_wdf_data;
  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    app_rd_data = '0;
  logic                                     app_rd_data_end = 1'b0;
  logic                                     app_rd_data_valid = 1'b0;
  logic                                     throttle;  // high stalls the mig

  // ------------------------------
  // ddr model state
  // ------------------------------
  logic [127:0] ddr_mem [int];   // index is addr / 8
  logic [127:0] ref_mem [int];   // what the memory should hold
  logic [2:0]   log_cmd [$];     // every accepted command
  logic [27:0]  log_addr [$];
  logic [27:0]  pend_addr [$];   // write cmd taken, data not yet
  logic [127:0] pend_data [$];   // write data taken, cmd not yet
  logic [27:0]  done_addr [$];   // completed write beats
  logic [1:0]   rd_v = '0;       // read return pipe
  logic [27:0]  rd_a [2];
  logic [27:0]  model_addr;
  logic [127:0] model_data;
  logic [31:0]  lcg_state;
  logic [127:0] held_beat;       // written before calibration

  assign app_rdy     = !throttle;
  assign app_wdf_rdy = !throttle;

  ddr3_arbit ddr3_arbit_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    fail_now($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic logic [15:0] next_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;  // lcg step
    return lcg_state[30:15];
  endfunction

  // unwritten beats carry their own address in every word pair
  function automatic logic [127:0] fill_beat(input logic [27:0] a);
    return {4'ha, a, 4'hb, a, 4'hc, a, 4'hd, a};
  endfunction

  function automatic logic [127:0] model_read(input logic [27:0] a);
    return ddr_mem.exists(int'(a >> 3)) ? ddr_mem[int'(a >> 3)] : fill_beat(a);
  endfunction

  function automatic logic [127:0] expected_beat(input logic [27:0] a);
    return ref_mem.exists(int'(a >> 3)) ? ref_mem[int'(a >> 3)] : fill_beat(a);
  endfunction

  // mig app model, read data two cycles after acceptance
  always @(posedge clk) begin
    rd_v[1]           <= rd_v[0];
    rd_a[1]           <= rd_a[0];
    rd_v[0]           <= app_en && app_rdy && (app_cmd == ddr3_arbit_pkg::CMD_READ);
    rd_a[0]           <= app_addr;
    app_rd_data_valid <= rd_v[1];
    app_rd_data_end   <= rd_v[1];  // every beat ends its burst
    app_rd_data       <= rd_v[1] ? model_read(rd_a[1]) : '0;
    if (app_en && app_rdy) begin
      log_cmd.push_back(app_cmd);
      log_addr.push_back(app_addr);
      if (app_cmd == ddr3_arbit_pkg::CMD_WRITE) pend_addr.push_back(app_addr);
    end
    if (app_wdf_wren && app_wdf_rdy) begin
      assert (app_wdf_end) else fail_now("write data accepted without app_wdf_end");
      pend_data.push_back(app_wdf_data);
    end
    if (pend_addr.size() > 0 && pend_data.size() > 0) begin  // pair cmd with data
      model_addr = pend_addr.pop_front();
      model_data = pend_data.pop_front();
      ddr_mem[int'(model_addr >> 3)] = model_data;
      done_addr.push_back(model_addr);
    end
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic drive_beat(output logic [127:0] beat);
    int          i;
    logic [15:0] w;
    for (i = 0; i < 8; i++) begin
      w                = next_word();
      beat[16*i +: 16] = w;  // word 0 lowest
      @(posedge clk);
      wr_din     <= w;
      wr_din_vld <= 1'b1;
    end
    @(posedge clk);
    wr_din_vld <= 1'b0;
  endtask

  task automatic expect_write(input logic [27:0] exp_addr, input logic [127:0] exp_beat);
    int          n;
    logic [27:0] got;
    n = 0;
    while (done_addr.size() == 0) begin
      @(negedge clk);
      n++;
      assert (n < TIMEOUT) else fail_now("timeout waiting for a write beat to reach memory");
    end
    got = done_addr.pop_front();
    assert (got == exp_addr) else report_mismatch("app_addr", 128'(got), 128'(exp_addr));
    assert (ddr_mem[int'(exp_addr >> 3)] == exp_beat)
      else report_mismatch("ddr_mem", ddr_mem[int'(exp_addr >> 3)], exp_beat);
    ref_mem[int'(exp_addr >> 3)] = exp_beat;
  endtask

  task automatic restart_wr_window();
    @(posedge clk);
    wr_req <= 1'b0;
    @(posedge clk);
    wr_req <= 1'b1;  // rising edge reloads first
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_and_calib();
    int i;
    @(negedge clk);
    assert (!app_en && !app_wdf_wren && !rd_dout_vld)
      else fail_now("app or read outputs active right after reset");
    drive_beat(held_beat);
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      assert (!app_en) else report_mismatch("app_en", 128'(app_en), 128'(0));
      assert (!app_wdf_wren) else report_mismatch("app_wdf_wren", 128'(app_wdf_wren), 128'(0));
      assert (!rd_dout_vld) else report_mismatch("rd_dout_vld", 128'(rd_dout_vld), 128'(0));
    end
  endtask

  task automatic write_packing();
    @(posedge clk);
    wr_req              <= 1'b1;
    init_calib_complete <= 1'b1;
    expect_write(wr_window.first, held_beat);
  endtask

  task automatic addr_wrap();
    int           i;
    logic [127:0] b;
    restart_wr_window();
    for (i = 0; i < 4; i++) begin
      drive_beat(b);
      expect_write(28'((i % 3) * 8), b);  // 0 8 16 0
    end
    restart_wr_window();
    drive_beat(b);
    expect_write(wr_window.first, b);
  endtask

  task automatic back_pressure();
    int           i;
    int           n;
    logic [127:0] b;
    @(posedge clk);
    throttle <= 1'b1;
    drive_beat(b);
    n = 0;
    @(negedge clk);
    while (!app_en) begin
      n++;
      assert (n < TIMEOUT) else fail_now("timeout waiting for app_en under back-pressure");
      @(negedge clk);
    end
    for (i = 0; i < 10; i++) begin  // stalled cmd must hold
      @(negedge clk);
      assert (app_en) else report_mismatch("app_en", 128'(app_en), 128'(1));
      assert (app_addr == 28'd8) else report_mismatch("app_addr", 128'(app_addr), 128'(8));
      assert (app_wdf_wren) else report_mismatch("app_wdf_wren", 128'(app_wdf_wren), 128'(1));
    end
    @(posedge clk);
    throttle <= 1'b0;
    expect_write(28'd8, b);
  endtask

  task automatic write_priority();
    int           n;
    logic [127:0] b;
    @(posedge clk);
    init_calib_complete <= 1'b0;  // hold off both engines
    log_cmd.delete();
    log_addr.delete();
    drive_beat(b);
    @(posedge clk);
    rd_req <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    init_calib_complete <= 1'b1;  // write and read due together
    n = 0;
    while (log_cmd.size() == 0) begin
      @(negedge clk);
      n++;
      assert (n < TIMEOUT) else fail_now("timeout waiting for a command after calibration");
    end
    assert (log_cmd[0] == ddr3_arbit_pkg::CMD_WRITE)
      else report_mismatch("app_cmd", 128'(log_cmd[0]), 128'(ddr3_arbit_pkg::CMD_WRITE));
    assert (log_addr[0] == 28'd16) else report_mismatch("app_addr", 128'(log_addr[0]), 128'(16));
    void'(log_cmd.pop_front());
    void'(log_addr.pop_front());
    expect_write(28'd16, b);
  endtask

  task automatic read_path();
    int           k;
    int           j;
    int           n;
    logic [127:0] b;
    for (k = 0; k < 32; k++) begin  // two read bursts
      b = expected_beat(28'(k * 8));
      for (j = 0; j < 8; j++) begin
        n = 0;
        @(negedge clk);
        while (!rd_dout_vld) begin
          n++;
          assert (n < TIMEOUT) else fail_now("timeout waiting for rd_dout_vld");
          @(negedge clk);
        end
        assert (rd_dout == b[16*j +: 16])
          else report_mismatch("rd_dout", 128'(rd_dout), 128'(b[16*j +: 16]));
      end
    end
    assert (log_cmd.size() >= 32) else fail_now("fewer read commands logged than beats returned");
    for (k = 0; k < 32; k++) begin  // second burst starts at 128
      assert (log_cmd[k] == ddr3_arbit_pkg::CMD_READ)
        else report_mismatch("app_cmd", 128'(log_cmd[k]), 128'(ddr3_arbit_pkg::CMD_READ));
      assert (log_addr[k] == 28'(k * 8))
        else report_mismatch("app_addr", 128'(log_addr[k]), 128'(k * 8));
    end
  endtask

  initial begin
    lcg_state = 32'd23719;
    rst_n               <= 1'b0;
    wr_req              <= 1'b0;
    wr_window           <= '{first: 28'd0, last: 28'd24};
    wr_din              <= '0;
    wr_din_vld          <= 1'b0;
    rd_req              <= 1'b0;
    rd_window           <= '{first: 28'd0, last: 28'd256};
    init_calib_complete <= 1'b0;
    throttle            <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_calib();
    write_packing();
    addr_wrap();
    back_pressure();
    write_priority();
    read_path();
    $display("test passed");
    $finish;
  end

endmodule

/* ddr3_arbit_properties.sv */
`timescale 1ns/100ps

module ddr3_arbit_properties (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic                                  init_calib_complete,
  input logic                                  app_en,
  input logic                                  app_rdy,
  input logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] app_addr,
  input logic                                  wr_start,
  input logic                                  rd_start,
  input logic                                  wr_busy,
  input logic                                  rd_busy
);

  // no command before the mig is calibrated
  calib_gate: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(app_en) |-> init_calib_complete)
    else $error("app_en rose while calibration was incomplete");

  // stalled command keeps its address
  addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    app_en && !app_rdy |=> app_en && $stable(app_addr))
    else $error("app_addr changed or app_en dropped while app_rdy was low");

  // a start goes out alone and only to two idle engines
  one_start: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_start || rd_start) |-> !(wr_start && rd_start) && !wr_busy && !rd_busy)
    else $error("start pulses overlapped or an engine was still busy at a start");

endmodule

bind ddr3_arbit ddr3_arbit_properties ddr3_arbit_properties_i (
  .clk, .rst_n, .init_calib_complete, .app_en, .app_rdy, .app_addr, .wr_start, .rd_start,
  .wr_busy, .rd_busy
);

/* ddr3_arbit.sv */
`timescale 1ns/100ps

module ddr3_arbit (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // user write side
  input  logic                                     wr_req,
  input  ddr3_arbit_pkg::addr_window_t             wr_window,
  input  logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] wr_din,
  input  logic                                     wr_din_vld,
  // user read side
  input  logic                                     rd_req,
  input  ddr3_arbit_pkg::addr_window_t             rd_window,
  output logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] rd_dout,
  output logic                                     rd_dout_vld,
  // mig app side
  input  logic                                     init_calib_complete,
  output logic                                     app_en,
  output logic [2:0]                               app_cmd,
  output logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0]    app_addr,
  input  logic                                     app_rdy,
  input  logic                                     app_wdf_rdy,
  output logic                                     app_wdf_wren,
  output logic                                     app_wdf_end,
  output logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    app_wdf_data,
  input  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    app_rd_data,
  input  logic                                     app_rd_data_end,
  input  logic                                     app_rd_data_valid
);

  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0] wr_beat, rd_beat;
  logic [ddr3_arbit_pkg::LEN_WIDTH-1:0]  wr_count, rd_count;
  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] wr_burst_addr, rd_burst_addr;
  logic wr_start, wr_busy, wr_done, wr_pop;
  logic rd_start, rd_busy, rd_done, rd_push, rd_empty;
  ddr3_arbit_pkg::app_req_t wr_app, rd_app, app;

  assign app_en      = app.en;
  assign app_cmd     = app.cmd;
  assign app_addr    = app.addr;
  assign rd_dout_vld = rd_req && !rd_empty;  // one word per valid cycle

  pack_fifo pack_fifo_i (.clk, .rst_n, .din(wr_din), .din_vld(wr_din_vld), .pop(wr_pop),
                         .dout(wr_beat), .count(wr_count));

  unpack_fifo unpack_fifo_i (.clk, .rst_n, .din(rd_beat), .push(rd_push), .pop(rd_dout_vld),
                             .dout(rd_dout), .empty(rd_empty), .count(rd_count));

  burst_arbiter burst_arbiter_i (.clk, .rst_n, .init_calib_complete, .rd_req, .wr_count,
                                 .rd_count, .wr_busy, .rd_busy, .wr_app, .rd_app,
                                 .wr_start, .rd_start, .app);

  // ------------------------------
  // write engine and its address
  // ------------------------------
  burst_addr_gen #(.STEP(ddr3_arbit_pkg::ADDR_WIDTH'(ddr3_arbit_pkg::WR_BURST_LEN) *
                         ddr3_arbit_pkg::ADDR_PER_BEAT))
    wr_addr_gen_i (.clk, .rst_n, .req(wr_req), .window(wr_window), .done(wr_done),
                   .burst_addr(wr_burst_addr));

  burst_writer burst_writer_i (.clk, .rst_n, .start(wr_start), .burst_addr(wr_burst_addr),
                               .beat(wr_beat), .app_rdy, .app_wdf_rdy, .app(wr_app),
                               .app_wdf_wren, .app_wdf_end, .app_wdf_data, .pop(wr_pop),
                               .busy(wr_busy), .done(wr_done));

  // ------------------------------
  // read engine and its address
  // ------------------------------
  burst_addr_gen #(.STEP(ddr3_arbit_pkg::ADDR_WIDTH'(ddr3_arbit_pkg::RD_BURST_LEN) *
                         ddr3_arbit_pkg::ADDR_PER_BEAT))
    rd_addr_gen_i (.clk, .rst_n, .req(rd_req), .window(rd_window), .done(rd_done),
                   .burst_addr(rd_burst_addr));

  burst_reader burst_reader_i (.clk, .rst_n, .start(rd_start), .burst_addr(rd_burst_addr),
                               .app_rdy, .app_rd_data, .app_rd_data_valid, .app(rd_app),
                               .push(rd_push), .beat(rd_beat), .busy(rd_busy),
                               .done(rd_done));

endmodule

/* burst_reader.sv */
`timescale 1ns/100ps

module burst_reader (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] burst_addr,
  input  logic                                  app_rdy,
  input  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0] app_rd_data,
  input  logic                                  app_rd_data_valid,
  output ddr3_arbit_pkg::app_req_t              app,
  output logic                                  push,
  output logic [ddr3_arbit_pkg::DATA_WIDTH-1:0] beat,
  output logic                                  busy,
  output logic                                  done
);

  ddr3_arbit_pkg::burst_state_e          state;
  logic [ddr3_arbit_pkg::LEN_WIDTH-1:0]  iss_cnt;  // commands accepted
  logic [ddr3_arbit_pkg::LEN_WIDTH-1:0]  ret_cnt;  // beats returned
  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] cur_addr;
  logic                                  cmd_acc;

  assign busy    = (state != ddr3_arbit_pkg::ST_IDLE);
  assign cmd_acc = app.en && app_rdy;
  assign push    = app_rd_data_valid && busy;
  assign beat    = app_rd_data;  // always a full beat
  assign app     = '{en: (state == ddr3_arbit_pkg::ST_ISSUE),
                     cmd: ddr3_arbit_pkg::CMD_READ, addr: cur_addr};

  always_ff @(posedge clk) begin
    if (start) cur_addr <= burst_addr;
    else if (cmd_acc) cur_addr <= cur_addr + ddr3_arbit_pkg::ADDR_PER_BEAT;
  end

  // ------------------------------
  // issue and return tracking
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ddr3_arbit_pkg::ST_IDLE;
      iss_cnt <= '0;
      ret_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ddr3_arbit_pkg::ST_IDLE: begin
          iss_cnt <= '0;
          ret_cnt <= '0;
          if (start) state <= ddr3_arbit_pkg::ST_ISSUE;
        end
        ddr3_arbit_pkg::ST_ISSUE: begin
          if (cmd_acc) begin
            iss_cnt <= iss_cnt + 1'b1;
            if (iss_cnt == ddr3_arbit_pkg::RD_BURST_LEN - 1'b1) begin
              state <= ddr3_arbit_pkg::ST_WAIT;  // all issued, data in flight
            end
          end
        end
        ddr3_arbit_pkg::ST_WAIT: ;  // closed by the last return
        default: state <= ddr3_arbit_pkg::ST_IDLE;
      endcase
      if (push) begin
        ret_cnt <= ret_cnt + 1'b1;
        if (ret_cnt == ddr3_arbit_pkg::RD_BURST_LEN - 1'b1) begin
          state <= ddr3_arbit_pkg::ST_IDLE;
          done  <= 1'b1;
        end
      end
    end
  end

endmodule

/* burst_writer.sv */
`timescale 1ns/100ps

module burst_writer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] burst_addr,
  input  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0] beat,  // pack fifo head
  input  logic                                  app_rdy,
  input  logic                                  app_wdf_rdy,
  output ddr3_arbit_pkg::app_req_t              app,
  output logic                                  app_wdf_wren,
  output logic                                  app_wdf_end,
  output logic [ddr3_arbit_pkg::DATA_WIDTH-1:0] app_wdf_data,
  output logic                                  pop,
  output logic                                  busy,
  output logic                                  done
);

  ddr3_arbit_pkg::burst_state_e          state;
  logic                                  data_ok;  // beat already taken
  logic                                  data_acc;
  logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] addr_q;

  assign busy         = (state != ddr3_arbit_pkg::ST_IDLE);
  assign pop          = start;  // head beat latched below
  assign app_wdf_wren = (state == ddr3_arbit_pkg::ST_WAIT) ||
                        ((state == ddr3_arbit_pkg::ST_ISSUE) && !data_ok);
  assign app_wdf_end  = app_wdf_wren;  // single-beat burst
  assign data_acc     = data_ok || (app_wdf_wren && app_wdf_rdy);
  assign app          = '{en: (state == ddr3_arbit_pkg::ST_ISSUE),
                          cmd: ddr3_arbit_pkg::CMD_WRITE, addr: addr_q};

  always_ff @(posedge clk) begin
    if (start) begin
      app_wdf_data <= beat;
      addr_q       <= burst_addr;  // held while the command waits
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ddr3_arbit_pkg::ST_IDLE;
      data_ok <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ddr3_arbit_pkg::ST_IDLE: begin
          data_ok <= 1'b0;
          if (start) state <= ddr3_arbit_pkg::ST_ISSUE;
        end
        ddr3_arbit_pkg::ST_ISSUE: begin
          data_ok <= data_acc;
          if (app_rdy && data_acc) begin
            state <= ddr3_arbit_pkg::ST_IDLE;  // both taken together
            done  <= 1'b1;
          end else if (app_rdy) begin
            state <= ddr3_arbit_pkg::ST_WAIT;  // cmd taken, data owed
          end
        end
        ddr3_arbit_pkg::ST_WAIT: begin
          if (app_wdf_rdy) begin
            state <= ddr3_arbit_pkg::ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ddr3_arbit_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

/* burst_arbiter.sv */
`timescale 1ns/100ps

module burst_arbiter (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 init_calib_complete,
  input  logic                                 rd_req,
  input  logic [ddr3_arbit_pkg::LEN_WIDTH-1:0] wr_count,  // beats waiting to go out
  input  logic [ddr3_arbit_pkg::LEN_WIDTH-1:0] rd_count,  // beats not yet consumed
  input  logic                                 wr_busy,
  input  logic                                 rd_busy,
  input  ddr3_arbit_pkg::app_req_t             wr_app,
  input  ddr3_arbit_pkg::app_req_t             rd_app,
  output logic                                 wr_start,
  output logic                                 rd_start,
  output ddr3_arbit_pkg::app_req_t             app
);

  logic can_start;
  logic wr_due;
  logic rd_due;

  // gate: calibrated, both engines idle, nothing in flight
  assign can_start = init_calib_complete && !wr_busy && !rd_busy && !wr_start && !rd_start;
  assign wr_due    = (wr_count >= ddr3_arbit_pkg::WR_BURST_LEN);
  assign rd_due    = rd_req && (rd_count < ddr3_arbit_pkg::RD_BURST_LEN);  // room for a burst

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_start <= 1'b0;
      rd_start <= 1'b0;
    end else begin
      wr_start <= can_start && wr_due;             // write wins
      rd_start <= can_start && !wr_due && rd_due;
    end
  end

  // writer owns the bus for its whole burst
  assign app = wr_busy ? wr_app : rd_app;

endmodule

/* burst_addr_gen.sv */
`timescale 1ns/100ps

module burst_addr_gen #(
  parameter logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] STEP = ddr3_arbit_pkg::ADDR_PER_BEAT
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  req,
  input  ddr3_arbit_pkg::addr_window_t          window,
  input  logic                                  done,
  output logic [ddr3_arbit_pkg::ADDR_WIDTH-1:0] burst_addr
);

  logic req_d;
  logic req_rise;

  assign req_rise = req && !req_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_d      <= 1'b0;
      burst_addr <= window.first;
    end else begin
      req_d <= req;
      if (req_rise) begin
        burst_addr <= window.first;  // new request restarts the window
      end else if (done) begin
        if (burst_addr < window.last - STEP) burst_addr <= burst_addr + STEP;
        else burst_addr <= window.first;  // wrap
      end
    end
  end

endmodule

/* unpack_fifo.sv */
`timescale 1ns/100ps

module unpack_fifo (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    din,
  input  logic                                     push,
  input  logic                                     pop,
  output logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] dout,
  output logic                                     empty,
  output logic [ddr3_arbit_pkg::LEN_WIDTH-1:0]     count
);

  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]       mem [ddr3_arbit_pkg::UNPACK_DEPTH];
  logic [ddr3_arbit_pkg::UNPACK_PTR_WIDTH-1:0] wptr;
  logic [ddr3_arbit_pkg::UNPACK_PTR_WIDTH-1:0] rptr;
  logic [ddr3_arbit_pkg::WORD_IDX_WIDTH-1:0]   widx;       // word within head beat
  logic                                        head_done;  // head beat fully read

  assign empty     = (count == '0);
  assign head_done = pop && (&widx);
  assign dout      = mem[rptr][widx*ddr3_arbit_pkg::DATA_IN_WIDTH +: ddr3_arbit_pkg::DATA_IN_WIDTH];

  always_ff @(posedge clk) begin
    if (push) mem[wptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      widx  <= '0;
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (pop) widx <= widx + 1'b1;  // wraps to 0 on head_done
      if (push) wptr <= wptr + 1'b1;
      if (head_done) rptr <= rptr + 1'b1;
      case ({push, head_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* pack_fifo.sv */
`timescale 1ns/100ps

module pack_fifo (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] din,
  input  logic                                    din_vld,
  input  logic                                    pop,
  output logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]    dout,
  output logic [ddr3_arbit_pkg::LEN_WIDTH-1:0]     count
);

  logic [ddr3_arbit_pkg::WORDS_PER_BEAT-1:0][ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] stage;
  logic [ddr3_arbit_pkg::WORDS_PER_BEAT-1:0][ddr3_arbit_pkg::DATA_IN_WIDTH-1:0] stage_nxt;
  logic [ddr3_arbit_pkg::DATA_WIDTH-1:0]       mem [ddr3_arbit_pkg::PACK_DEPTH];
  logic [ddr3_arbit_pkg::PACK_PTR_WIDTH-1:0]   wptr;
  logic [ddr3_arbit_pkg::PACK_PTR_WIDTH-1:0]   rptr;
  logic [ddr3_arbit_pkg::WORD_IDX_WIDTH-1:0]   widx;  // next word slot
  logic                                        push;

  always_comb begin
    stage_nxt       = stage;
    stage_nxt[widx] = din;  // low word lands first
  end

  assign push = din_vld && (&widx);  // eighth word completes the beat
  assign dout = mem[rptr];           // fwft head

  always_ff @(posedge clk) begin
    if (din_vld) stage <= stage_nxt;
  end

  always_ff @(posedge clk) begin
    if (push) mem[wptr] <= stage_nxt;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      widx  <= '0;
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (din_vld) widx <= widx + 1'b1;
      if (push) wptr <= wptr + 1'b1;
      if (pop) rptr <= rptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* ddr3_arbit_pkg.sv */
package ddr3_arbit_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int ADDR_WIDTH       = 28;                          // mig app address
  localparam int DATA_WIDTH       = 128;                         // one app beat
  localparam int DATA_IN_WIDTH    = 16;                          // user word
  localparam int WORDS_PER_BEAT   = DATA_WIDTH / DATA_IN_WIDTH;  // 8 words per beat
  localparam int WORD_IDX_WIDTH   = $clog2(WORDS_PER_BEAT);
  localparam int LEN_WIDTH        = 6;                           // beat counters, fifo counts

  // ------------------------------
  // buffering and bursts
  // ------------------------------
  localparam int PACK_DEPTH       = 16;                          // write beats held
  localparam int UNPACK_DEPTH     = 32;                          // read beats held
  localparam int PACK_PTR_WIDTH   = $clog2(PACK_DEPTH);
  localparam int UNPACK_PTR_WIDTH = $clog2(UNPACK_DEPTH);

  localparam logic [ADDR_WIDTH-1:0] ADDR_PER_BEAT = ADDR_WIDTH'(8);  // 8 x 16-bit columns
  localparam logic [LEN_WIDTH-1:0]  WR_BURST_LEN  = LEN_WIDTH'(1);
  localparam logic [LEN_WIDTH-1:0]  RD_BURST_LEN  = LEN_WIDTH'(16);

  // ------------------------------
  // types
  // ------------------------------
  typedef enum logic [2:0] {
    CMD_WRITE = 3'd0,  // mig write
    CMD_READ  = 3'd1   // mig read
  } app_cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE,   // waiting for start
    ST_ISSUE,  // command on the bus
    ST_WAIT    // command taken, data still owed
  } burst_state_e;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] first;  // reload and wrap target
    logic [ADDR_WIDTH-1:0] last;   // window end
  } addr_window_t;

  typedef struct packed {
    logic                  en;
    app_cmd_e              cmd;
    logic [ADDR_WIDTH-1:0] addr;
  } app_req_t;  // 32 bits

endpackage
